// ==== mmuTlb_cfg.svh ====
`ifndef MMUTLB_CFG_SVH
`define MMUTLB_CFG_SVH

// address and page geometry
`define MMU_ADDR_W     48
`define MMU_PAGE_SH    12        // 4 KB pages
`define TLB_SETS       16
`define TLB_IDX_W      4
`define TLB_WAYS       4
`define TLB_VPN_LO     76        // vpn sits at 111:76 of the entry word

// operation codes, bit 3 = load, bit 4 = store
`define OPM_NONE       5'h00
`define OPM_LDTLB      5'h01
`define OPM_INVTLB     5'h02

// status codes
`define OK_READY       2'b00
`define OK_DONE        2'b01
`define OK_FAULT       2'b11

// exception codes
`define EXC_MISS       16'hA001
`define EXC_READ       16'h8002
`define EXC_WRITE      16'h8001
`define EXC_USERBYP    16'h8003

`endif

// ==== mmuPkg.sv ====
`include "mmuTlb_cfg.svh"

package mmuPkg;

	// virtual and physical byte addresses
	typedef logic [`MMU_ADDR_W-1:0] vaddrT;
	typedef logic [`MMU_ADDR_W-1:0] paddrT;

	// load-entry word
	// hi half: vpn at 111:76
	// lo half: ppn at 47:12, bit 0 valid, 1 read, 2 write, 3 user
	typedef logic [127:0] tlbEntryT;

	// hashed set index
	typedef logic [`TLB_IDX_W-1:0] tlbIdxT;

	// bit 0 read, bit 1 write, bit 2 user
	typedef logic [2:0] tlbRightsT;

	typedef logic [15:0] excT;     // exception code
	typedef logic [1:0] okT;       // status code
	typedef logic [4:0] opmT;      // operation code

	// control and status register words
	// mmcr bit 0 enables the mmu, sr bit 30 is supervisor mode
	typedef logic [63:0] ctrlT;

endpackage

// ==== mmuOpDecode.sv ====
`timescale 1ns/1ps

`include "mmuTlb_cfg.svh"

module mmuOpDecode
(
	input  mmuPkg::opmT    opm,
	input  mmuPkg::vaddrT  vaddr,
	input  mmuPkg::ctrlT   mmcr,
	input  mmuPkg::ctrlT   sr,
	output logic           isLoad,
	output logic           isStore,
	output logic           isLdtlb,
	output logic           isInvtlb,
	output logic           translate,
	output logic           userMode,
	output mmuPkg::tlbIdxT setIdx
);

	logic mmuEnable;
	logic bypassRegion;

	// operation strobes
	assign isLoad   = opm[3];
	assign isStore  = opm[4];
	assign isLdtlb  = (opm == `OPM_LDTLB);
	assign isInvtlb = (opm == `OPM_INVTLB);

	assign mmuEnable    = mmcr[0];
	assign bypassRegion = vaddr[31];    // upper half of the 32-bit space is untranslated

	// translate only with the mmu on and outside the bypass region
	assign translate = mmuEnable && !bypassRegion;

	assign userMode = !sr[30];          // sr.md clear means user

	// page number folded onto itself, spreads neighbouring pages over sets
	// same index for lookup and for ldtlb insertion
	assign setIdx = vaddr[`MMU_PAGE_SH +: `TLB_IDX_W]
		^ vaddr[`MMU_PAGE_SH + `TLB_IDX_W +: `TLB_IDX_W];

endmodule

// ==== mmuTlbArray.sv ====
`timescale 1ns/1ps

`include "mmuTlb_cfg.svh"

module mmuTlbArray
(
	input  logic              clock,
	input  logic              arstN,
	input  logic              isLdtlb,
	input  logic              isInvtlb,
	input  mmuPkg::tlbIdxT    setIdx,
	input  mmuPkg::vaddrT     vaddr,
	input  mmuPkg::tlbEntryT  entryData,
	output logic              hit,
	output mmuPkg::paddrT     ppn,
	output mmuPkg::tlbRightsT rights
);

	localparam int vpnW = `MMU_ADDR_W - `MMU_PAGE_SH;

	// entry storage, way 0 holds the newest entry of a set
	mmuPkg::tlbEntryT wayMem [`TLB_WAYS-1:0][`TLB_SETS-1:0];

	// one bit per set, a set bit hides every entry of that set
	logic [`TLB_SETS-1:0] invMask;

	mmuPkg::tlbEntryT     rdEntry [`TLB_WAYS-1:0];   // read view with mask applied
	logic [`TLB_WAYS-1:0] wayMatch;

	always_comb
	begin
		for (int w = 0; w < `TLB_WAYS; w++)
		begin
			rdEntry[w] = wayMem[w][setIdx];
			if (invMask[setIdx])
				rdEntry[w][0] = 1'b0;    // flushed set reads as invalid
			wayMatch[w] = rdEntry[w][0]
				&& (rdEntry[w][`TLB_VPN_LO +: vpnW] == vaddr[`MMU_ADDR_W-1:`MMU_PAGE_SH]);
		end
	end

	// lowest matching way wins, walk downward so it is assigned last
	always_comb
	begin
		hit    = |wayMatch;
		ppn    = '0;
		rights = '0;
		for (int w = `TLB_WAYS-1; w >= 0; w--)
		begin
			if (wayMatch[w])
			begin
				ppn[`MMU_ADDR_W-1:`MMU_PAGE_SH] = rdEntry[w][`MMU_ADDR_W-1:`MMU_PAGE_SH];
				rights = rdEntry[w][3:1];    // read, write, user
			end
		end
	end

	// ldtlb pushes the new word into way 0 and the rest down one way
	// the masked view is shifted, so flushed entries stay invalid
	always_ff @(posedge clock)
	begin
		if (isLdtlb)
		begin
			wayMem[0][setIdx] <= entryData;
			for (int w = 1; w < `TLB_WAYS; w++)
				wayMem[w][setIdx] <= rdEntry[w-1];    // oldest way drops out
		end
	end

	// reset leaves every set flushed
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			invMask <= '1;
		end
		else if (isInvtlb)
		begin
			invMask <= '1;
		end
		else if (isLdtlb)
		begin
			invMask[setIdx] <= 1'b0;    // set becomes live again
		end
	end

	// insertion and flush would fight over the mask and the shifted ways
	ldtlbInvtlbExclusive: assert property (
		@(posedge clock) disable iff (!arstN)
		!(isLdtlb && isInvtlb)
	) else $error("ldtlb and invtlb in the same cycle");

endmodule

// ==== mmuAccessCheck.sv ====
`timescale 1ns/1ps

`include "mmuTlb_cfg.svh"

module mmuAccessCheck
(
	input  logic              clock,
	input  logic              arstN,
	input  logic              isLoad,
	input  logic              isStore,
	input  logic              isLdtlb,
	input  logic              isInvtlb,
	input  logic              translate,
	input  logic              userMode,
	input  logic              hit,
	input  mmuPkg::paddrT     ppn,
	input  mmuPkg::tlbRightsT rights,
	input  mmuPkg::vaddrT     vaddr,
	input  mmuPkg::opmT       opm,
	output mmuPkg::paddrT     paddr,
	output mmuPkg::excT       exc,
	output mmuPkg::okT        ok,
	output mmuPkg::opmT       opmOut
);

	logic          isAccess;
	logic          rwFail;
	logic          userFail;
	mmuPkg::excT   excNext;
	mmuPkg::okT    okNext;
	mmuPkg::paddrT paddrNext;

	assign isAccess = isLoad || isStore;
	assign rwFail   = isLoad ? !rights[0] : !rights[1];
	assign userFail = userMode && !rights[2];    // user mode on a supervisor page

	// miss first, then rights, then user
	always_comb
	begin
		excNext = '0;
		if (isAccess)
		begin
			if (translate)
			begin
				if (!hit)
					excNext = `EXC_MISS;
				else if (rwFail || userFail)
					excNext = isLoad ? `EXC_READ : `EXC_WRITE;
			end
			else if (vaddr[31] && userMode)
			begin
				excNext = `EXC_USERBYP;    // user code may not touch the bypass region
			end
		end
	end

	// tlb maintenance ops pass the address through untranslated
	always_comb
	begin
		if (translate && !isLdtlb && !isInvtlb)
			paddrNext = {ppn[`MMU_ADDR_W-1:`MMU_PAGE_SH], vaddr[`MMU_PAGE_SH-1:0]};
		else
			paddrNext = vaddr;
	end

	always_comb
	begin
		if (excNext != '0)
			okNext = `OK_FAULT;
		else if (opm == `OPM_NONE)
			okNext = `OK_READY;
		else
			okNext = `OK_DONE;
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			exc    <= '0;
			ok     <= `OK_READY;
			opmOut <= `OPM_NONE;
		end
		else
		begin
			exc    <= excNext;
			ok     <= okNext;
			opmOut <= opm;
		end
	end

	always_ff @(posedge clock)
		paddr <= paddrNext;    // address payload

	// a fault status only ever follows a load or store opcode
	faultOnlyOnAccess: assert property (
		@(posedge clock) disable iff (!arstN)
		(ok == `OK_FAULT) |-> (opmOut[3] || opmOut[4])
	) else $error("fault status on an operation that is not a load or store");

endmodule

// ==== mmuTlbTop.sv ====
`timescale 1ns/1ps

module mmuTlbTop
(
	input  logic             clock,
	input  logic             arstN,
	input  mmuPkg::opmT      opm,
	input  mmuPkg::vaddrT    vaddr,
	input  mmuPkg::tlbEntryT entryData,
	input  mmuPkg::ctrlT     mmcr,
	input  mmuPkg::ctrlT     sr,
	output mmuPkg::paddrT    paddr,
	output mmuPkg::excT      exc,
	output mmuPkg::okT       ok,
	output mmuPkg::opmT      opmOut
);

	logic              isLoad;
	logic              isStore;
	logic              isLdtlb;
	logic              isInvtlb;
	logic              translate;
	logic              userMode;
	mmuPkg::tlbIdxT    setIdx;
	logic              hit;
	mmuPkg::paddrT     ppn;
	mmuPkg::tlbRightsT rights;

	mmuOpDecode mmuOpDecode_inst (
		.opm(opm), .vaddr(vaddr), .mmcr(mmcr), .sr(sr),
		.isLoad(isLoad), .isStore(isStore), .isLdtlb(isLdtlb), .isInvtlb(isInvtlb),
		.translate(translate), .userMode(userMode), .setIdx(setIdx)
	);

	// lookup is combinational, the check stage registers the result
	mmuTlbArray mmuTlbArray_inst (
		.clock(clock), .arstN(arstN), .isLdtlb(isLdtlb), .isInvtlb(isInvtlb),
		.setIdx(setIdx), .vaddr(vaddr), .entryData(entryData),
		.hit(hit), .ppn(ppn), .rights(rights)
	);

	mmuAccessCheck mmuAccessCheck_inst (
		.clock(clock), .arstN(arstN),
		.isLoad(isLoad), .isStore(isStore), .isLdtlb(isLdtlb), .isInvtlb(isInvtlb),
		.translate(translate), .userMode(userMode),
		.hit(hit), .ppn(ppn), .rights(rights), .vaddr(vaddr), .opm(opm),
		.paddr(paddr), .exc(exc), .ok(ok), .opmOut(opmOut)
	);

endmodule

// ==== mmuTlbChecker.sv ====
`timescale 1ns/1ps

`include "mmuTlb_cfg.svh"

module mmuTlbChecker
(
	input  logic             clock,
	input  logic             arstN,
	input  mmuPkg::opmT      opm,
	input  mmuPkg::vaddrT    vaddr,
	input  mmuPkg::tlbEntryT entryData,
	input  mmuPkg::ctrlT     mmcr,
	input  mmuPkg::ctrlT     sr,
	input  mmuPkg::paddrT    paddr,
	input  mmuPkg::excT      exc,
	input  mmuPkg::okT       ok,
	input  mmuPkg::opmT      opmOut,
	input  logic [3:0]       testId,
	output int               errorCount,
	output int               checkCount
);

	// shadow buffer, way 0 newest
	logic        shValid [`TLB_WAYS][`TLB_SETS];
	logic [35:0] shVpn [`TLB_WAYS][`TLB_SETS];
	logic [35:0] shPpn [`TLB_WAYS][`TLB_SETS];
	logic [2:0]  shRights [`TLB_WAYS][`TLB_SETS];    // read, write, user

	logic          pendValid;
	logic          pendAddr;    // paddr compared on clean accesses only
	mmuPkg::paddrT pendPaddr;
	mmuPkg::excT   pendExc;
	mmuPkg::okT    pendOk;
	mmuPkg::opmT   pendOpm;
	logic [3:0]    lastTest;
	logic [3:0]    ldIdx;
	int            testBase;

	function automatic void refResult(input mmuPkg::opmT op, input mmuPkg::vaddrT va,
		input logic mmuOn, input logic user, output mmuPkg::paddrT pa,
		output mmuPkg::excT ex, output mmuPkg::okT st);
		logic [3:0]  idx;
		logic        found;
		logic [35:0] ppnHit;
		logic [2:0]  rwu;
		idx = va[15:12] ^ va[19:16];
		found = 1'b0;
		ppnHit = '0;
		rwu = '0;
		for (int w = 0; w < `TLB_WAYS; w++)
		begin
			if (!found && shValid[w][idx] && shVpn[w][idx] == va[47:12])
			begin
				found = 1'b1;
				ppnHit = shPpn[w][idx];
				rwu = shRights[w][idx];
			end
		end
		pa = va;
		ex = '0;
		if (op[3] || op[4])
		begin
			if (mmuOn && !va[31])
			begin
				pa = {ppnHit, va[11:0]};
				if (!found)
					ex = `EXC_MISS;
				else if ((op[3] && !rwu[0]) || (op[4] && !rwu[1]) || (user && !rwu[2]))
					ex = op[3] ? `EXC_READ : `EXC_WRITE;
			end
			else if (va[31] && user)
				ex = `EXC_USERBYP;
		end
		st = (ex != '0) ? `OK_FAULT : ((op == `OPM_NONE) ? `OK_READY : `OK_DONE);
	endfunction

	task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] expv);
		$display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expv);
		errorCount++;
	endtask

	// outputs settle after the rising edge, inputs after edge + 2 ns
	always @(negedge clock)
	begin
		if (!arstN)
		begin
			for (int w = 0; w < `TLB_WAYS; w++)
				for (int s = 0; s < `TLB_SETS; s++)
					shValid[w][s] = 1'b0;
			pendValid = 1'b0;
			errorCount = 0;
			checkCount = 0;
			testBase = 0;
			lastTest = testId;
		end
		else
		begin
			if (pendValid)
			begin
				checkCount++;
				if (exc !== pendExc)
					mismatch("exc", 64'(exc), 64'(pendExc));
				if (ok !== pendOk)
					mismatch("ok", 64'(ok), 64'(pendOk));
				if (opmOut !== pendOpm)
					mismatch("opmOut", 64'(opmOut), 64'(pendOpm));
				if (pendAddr && paddr !== pendPaddr)
					mismatch("paddr", 64'(paddr), 64'(pendPaddr));
			end
			if (testId != lastTest)
			begin
				if (lastTest != 4'd0)
					$display("test %0d finished with %0d errors", lastTest, errorCount - testBase);
				lastTest = testId;
				testBase = errorCount;
			end
			refResult(opm, vaddr, mmcr[0], !sr[30], pendPaddr, pendExc, pendOk);
			pendOpm = opm;
			pendAddr = (opm[3] || opm[4]) && pendExc == '0;
			pendValid = 1'b1;
			// shadow follows the insertion and flush rules
			if (opm == `OPM_INVTLB)
			begin
				for (int w = 0; w < `TLB_WAYS; w++)
					for (int s = 0; s < `TLB_SETS; s++)
						shValid[w][s] = 1'b0;
			end
			else if (opm == `OPM_LDTLB)
			begin
				ldIdx = vaddr[15:12] ^ vaddr[19:16];
				for (int w = `TLB_WAYS-1; w > 0; w--)
				begin
					shValid[w][ldIdx] = shValid[w-1][ldIdx];
					shVpn[w][ldIdx] = shVpn[w-1][ldIdx];
					shPpn[w][ldIdx] = shPpn[w-1][ldIdx];
					shRights[w][ldIdx] = shRights[w-1][ldIdx];
				end
				shValid[0][ldIdx] = entryData[0];
				shVpn[0][ldIdx] = entryData[111:76];
				shPpn[0][ldIdx] = entryData[47:12];
				shRights[0][ldIdx] = entryData[3:1];
			end
		end
	end

endmodule

// ==== mmuTlbTb.sv ====
`timescale 1ns/1ps

`include "mmuTlb_cfg.svh"

module mmuTlbTb;

	localparam int idleCount = 3;
	// reset, six tests, idle gaps and the final wait
	localparam int totalOps = 3 + 20 + 16 + 24 + 10 + 44 + 9 + 6 * idleCount + 2;
	localparam mmuPkg::opmT opLoad = 5'h08;
	localparam mmuPkg::opmT opStore = 5'h10;
	localparam mmuPkg::ctrlT superSr = 64'h4000_0000;

	logic             clock;
	logic             arstN;
	mmuPkg::opmT      opm;
	mmuPkg::vaddrT    vaddr;
	mmuPkg::tlbEntryT entryData;
	mmuPkg::ctrlT     mmcr;
	mmuPkg::ctrlT     sr;
	mmuPkg::paddrT    paddr;
	mmuPkg::excT      exc;
	mmuPkg::okT       ok;
	mmuPkg::opmT      opmOut;
	logic [3:0]       testId;
	int               errorCount;
	int               checkCount;
	int               seed;
	logic [31:0]      rnd;
	logic [35:0]      pg;
	logic [35:0]      pages [8];

	mmuTlbTop mmuTlbTop_inst (
		.clock(clock), .arstN(arstN), .opm(opm), .vaddr(vaddr), .entryData(entryData),
		.mmcr(mmcr), .sr(sr), .paddr(paddr), .exc(exc), .ok(ok), .opmOut(opmOut)
	);

	mmuTlbChecker mmuTlbChecker_inst (
		.clock(clock), .arstN(arstN), .opm(opm), .vaddr(vaddr), .entryData(entryData),
		.mmcr(mmcr), .sr(sr), .paddr(paddr), .exc(exc), .ok(ok), .opmOut(opmOut),
		.testId(testId), .errorCount(errorCount), .checkCount(checkCount)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic mmuPkg::tlbEntryT makeEntry(input logic [35:0] vpn,
		input logic [35:0] ppn, input logic [2:0] rwu);
		mmuPkg::tlbEntryT e;
		e = '0;
		e[111:76] = vpn;
		e[47:12] = ppn;
		e[3:0] = {rwu[2], rwu[1], rwu[0], 1'b1};    // user, write, read, valid
		return e;
	endfunction

	// page number with address bit 31 clear
	function automatic logic [35:0] randPage();
		logic [31:0] lo;
		logic [31:0] hi;
		lo = $random(seed);
		hi = $random(seed);
		return {hi[3:0], lo} & 36'hF_FFF7_FFFF;
	endfunction

	task automatic applyOp(input mmuPkg::opmT op, input logic [35:0] page,
		input logic [11:0] offs, input mmuPkg::tlbEntryT ent);
		opm = op;
		vaddr = {page, offs};
		entryData = ent;
		@(posedge clock);
		#2;
	endtask

	task automatic idleOps();
		repeat (idleCount) applyOp(`OPM_NONE, '0, '0, '0);
	endtask

	initial
	begin
		seed = 32'hb06b;
		arstN = 1'b0;
		opm = `OPM_NONE;
		vaddr = '0;
		entryData = '0;
		mmcr = '0;
		sr = superSr;
		testId = 4'd0;
		repeat (3) @(posedge clock);
		#2;
		arstN = 1'b1;

		testId = 4'd1;    // mmu off, straight through
		for (int i = 0; i < 16; i++)
		begin
			rnd = $random(seed);
			pg = randPage();
			pg[19] = rnd[20];
			applyOp(rnd[0] ? opStore : opLoad, pg, rnd[11:0], '0);
		end
		repeat (4) applyOp(`OPM_NONE, randPage(), '0, '0);
		idleOps();

		testId = 4'd2;    // nothing loaded yet
		mmcr = 64'h1;
		for (int i = 0; i < 16; i++)
		begin
			rnd = $random(seed);
			sr = rnd[1] ? superSr : 64'h0;
			applyOp(rnd[0] ? opStore : opLoad, randPage(), rnd[15:4], '0);
		end
		idleOps();

		testId = 4'd3;
		sr = superSr;
		for (int i = 0; i < 8; i++)
		begin
			pages[i] = randPage();
			applyOp(`OPM_LDTLB, pages[i], '0, makeEntry(pages[i], randPage(), 3'b111));
		end
		for (int i = 0; i < 8; i++)
		begin
			rnd = $random(seed);
			applyOp(opLoad, pages[i], rnd[11:0], '0);
			applyOp(opStore, pages[i], rnd[23:12], '0);
		end
		idleOps();

		testId = 4'd4;    // all five land in set 0
		for (int k = 1; k <= 5; k++)
		begin
			pg = 36'h12300 + 36'(k) * 36'h11;
			applyOp(`OPM_LDTLB, pg, '0, makeEntry(pg, 36'h5500 + 36'(k), 3'b111));
		end
		for (int k = 1; k <= 5; k++)
			applyOp(opLoad, 36'h12300 + 36'(k) * 36'h11, 12'h0a4, '0);
		idleOps();

		testId = 4'd5;    // every rights combination, one per set
		for (int code = 0; code < 8; code++)
		begin
			pg = 36'h40000 + 36'(code) * 36'h10;
			applyOp(`OPM_LDTLB, pg, '0, makeEntry(pg, 36'hABC00 + 36'(code), 3'(code)));
			for (int m = 0; m < 2; m++)
			begin
				sr = m ? 64'h0 : superSr;
				applyOp(opLoad, pg, 12'h123, '0);
				applyOp(opStore, pg, 12'h456, '0);
			end
		end
		for (int m = 0; m < 4; m++)
		begin
			sr = m[1] ? superSr : 64'h0;
			applyOp(m[0] ? opStore : opLoad, 36'h80001, 12'h010, '0);    // bypass region
		end
		sr = superSr;
		idleOps();

		testId = 4'd6;
		applyOp(`OPM_INVTLB, '0, '0, '0);
		for (int code = 0; code < 8; code++)
			applyOp(opLoad, 36'h40000 + 36'(code) * 36'h10, 12'h020, '0);
		idleOps();

		testId = 4'd7;
		repeat (2) @(posedge clock);
		$display("6 tests, %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// bound on the whole run
	initial
	begin
		#((totalOps + 20) * 20);
		$display("Timeout after %0d cycles, the tests did not complete", totalOps + 20);
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== mmuTlb.f ====
+incdir+.
mmuPkg.sv
mmuOpDecode.sv
mmuTlbArray.sv
mmuAccessCheck.sv
mmuTlbTop.sv
mmuTlbChecker.sv
mmuTlbTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the tlb testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mmuTlbTb -f mmuTlb.f -o simTlb

simOut=$(./obj_dir/simTlb 2>&1) || true
echo "$simOut"

grep -qx "Finished with no errors" <<< "$simOut"
